// ==== alu.sv ====
`timescale 1ns/10ps

module alu import stack_core_pkg::*; (
  input logic clk,
  input logic reset,
  stack_core_if.alu ctrl,
  input word_t top,
  input word_t second,
  output word_t result
);

  logic carry;
  logic carry_in;
  word_t operand;
  logic [WORD_WIDTH:0] sum;
  logic arith_op;

  // Subtraction is second plus the inverted top plus one, so the carry
  // out is set exactly when no borrow occurs
  always_comb begin
    operand = top;
    carry_in = 1'b0;
    case (ctrl.alu_op)
      ALU_ADDC: carry_in = carry;
      ALU_SUB: begin
        operand = ~top;
        carry_in = 1'b1;
      end
      default: ;
    endcase
    sum = {1'b0, second} + {1'b0, operand} + (WORD_WIDTH + 1)'(carry_in);
  end

  always_comb begin
    case (ctrl.alu_op)
      ALU_AND: result = second & top;
      ALU_OR: result = second | top;
      ALU_XOR: result = second ^ top;
      default: result = sum[WORD_WIDTH-1:0];
    endcase
  end

  assign arith_op = ctrl.alu_op inside {ALU_ADD, ALU_ADDC, ALU_SUB};

  // Logic operations keep the previous carry
  always_ff @(posedge clk) begin
    if (reset) begin
      carry <= 1'b0;
    end else if (ctrl.alu_en && arith_op) begin
      carry <= sum[WORD_WIDTH];
    end
  end

endmodule

// ==== core_chk.sv ====
`timescale 1ns/10ps

module core_chk import stack_core_pkg::*; #(
  parameter int PROG_ADDR_WIDTH = 8
) (
  input logic clk,
  input logic reset,
  input logic [PROG_ADDR_WIDTH-1:0] programmem_addr,
  input instr_t programmem_read_value,
  input logic mainmem_we
);

  // Number of failed properties so far
  int unsigned failures = 0;

  // Program memory is addressed from zero while reset is held
  reset_addr_zero: assert property (
    @(posedge clk) reset |-> programmem_addr == '0
  ) else begin
    failures++;
    $error("programmem_addr is not zero during reset");
  end

  // No write can happen during reset or in the cycle that follows it
  reset_no_write: assert property (
    @(posedge clk) (reset || $fell(reset)) |-> !mainmem_we
  ) else begin
    failures++;
    $error("mainmem_we is high during or right after reset");
  end

  we_known: assert property (
    @(posedge clk) !$isunknown(mainmem_we)
  ) else begin
    failures++;
    $error("mainmem_we is unknown");
  end

  // A literal followed by JMP sends the next fetch to that literal
  jump_target: assert property (
    @(posedge clk) disable iff (reset)
    (programmem_read_value[LITERAL_FLAG_BIT] ##1 programmem_read_value == OP_JMP)
      |-> programmem_addr ==
          PROG_ADDR_WIDTH'($past(programmem_read_value[LITERAL_FLAG_BIT-1:0]))
  ) else begin
    failures++;
    $error("Fetch after JMP does not go to the jump target");
  end

endmodule

// ==== core_top.sv ====
`timescale 1ns/10ps

module core_top import stack_core_pkg::*; #(
  parameter int PROG_ADDR_WIDTH = 8,
  parameter int MAIN_ADDR_WIDTH = 8,
  parameter int DSTACK_DEPTH_MAG = 4,
  parameter int LSTACK_DEPTH = 3
) (
  input logic clk,
  input logic reset,
  output logic [PROG_ADDR_WIDTH-1:0] programmem_addr,
  input instr_t programmem_read_value,
  output logic mainmem_we,
  output logic [MAIN_ADDR_WIDTH-1:0] mainmem_write_addr,
  output word_t mainmem_write_value
);

  stack_core_if ctrl ();

  word_t top;
  word_t second;
  word_t result;
  word_t index;
  logic loop_exit;
  logic loop_iterate;
  logic [PROG_ADDR_WIDTH-1:0] loop_begin;
  logic [PROG_ADDR_WIDTH-1:0] loop_after_end;
  logic [PROG_ADDR_WIDTH-1:0] pc;

  instruction_decoder decoder (
    .instruction(programmem_read_value),
    .ctrl(ctrl.decoder)
  );

  alu alu_unit (
    .clk, .reset, .ctrl(ctrl.alu), .top, .second, .result
  );

  data_stack #(.DSTACK_DEPTH_MAG(DSTACK_DEPTH_MAG)) dstack (
    .clk, .reset, .ctrl(ctrl.stack), .result, .index, .top, .second
  );

  loop_stack #(.PROG_ADDR_WIDTH(PROG_ADDR_WIDTH), .LSTACK_DEPTH(LSTACK_DEPTH)) lstack (
    .clk, .reset, .ctrl(ctrl.sequencer), .pc, .top, .second, .index,
    .loop_exit, .loop_iterate, .loop_begin, .loop_after_end
  );

  pc_sequencer #(.PROG_ADDR_WIDTH(PROG_ADDR_WIDTH)) sequencer (
    .clk, .reset, .ctrl(ctrl.sequencer), .top,
    .loop_exit, .loop_iterate, .loop_begin, .loop_after_end,
    .pc, .programmem_addr
  );

  // STORE writes second to the address held in top
  assign mainmem_we = ctrl.store;
  assign mainmem_write_addr = top[MAIN_ADDR_WIDTH-1:0];
  assign mainmem_write_value = second;

endmodule

// ==== data_stack.sv ====
`timescale 1ns/10ps

module data_stack import stack_core_pkg::*; #(
  parameter int DSTACK_DEPTH_MAG = 4
) (
  input logic clk,
  input logic reset,
  stack_core_if.stack ctrl,
  input word_t result,
  input word_t index,
  output word_t top,
  output word_t second
);

  localparam int SPILL_DEPTH = 1 << DSTACK_DEPTH_MAG;

  // Entries below second live here, ptr is the next free slot
  word_t spill [SPILL_DEPTH];
  logic [DSTACK_DEPTH_MAG-1:0] ptr;
  logic [DSTACK_DEPTH_MAG-1:0] ptr_dec1;
  logic [DSTACK_DEPTH_MAG-1:0] ptr_dec2;
  word_t new_top;

  assign ptr_dec1 = ptr - DSTACK_DEPTH_MAG'(1);
  assign ptr_dec2 = ptr - DSTACK_DEPTH_MAG'(2);

  always_comb begin
    case (ctrl.top_src)
      SRC_LITERAL: new_top = word_t'(ctrl.literal);
      SRC_ALU: new_top = result;
      SRC_INDEX: new_top = index;
      default: new_top = top;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ctrl.stack_move == MOVE_PUSH) begin
      spill[ptr] <= second;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      top <= '0;
      second <= '0;
      ptr <= '0;
    end else begin
      case (ctrl.stack_move)
        MOVE_PUSH: begin
          top <= new_top;
          second <= top;
          ptr <= ptr + DSTACK_DEPTH_MAG'(1);
        end
        MOVE_POP: begin
          top <= second;
          second <= spill[ptr_dec1];
          ptr <= ptr_dec1;
        end
        MOVE_POP_REPLACE: begin
          top <= new_top;
          second <= spill[ptr_dec1];
          ptr <= ptr_dec1;
        end
        MOVE_POP_TWO: begin
          top <= spill[ptr_dec1];
          second <= spill[ptr_dec2];
          ptr <= ptr_dec2;
        end
        MOVE_SWAP: begin
          top <= second;
          second <= top;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== instruction_decoder.sv ====
`timescale 1ns/10ps

module instruction_decoder import stack_core_pkg::*; (
  input instr_t instruction,
  stack_core_if.decoder ctrl
);

  always_comb begin
    ctrl.alu_op = ALU_ADD;
    ctrl.alu_en = 1'b0;
    ctrl.stack_move = MOVE_HOLD;
    ctrl.top_src = SRC_COPY;
    ctrl.literal = instruction[LITERAL_FLAG_BIT-1:0];
    ctrl.store = 1'b0;
    ctrl.jump = 1'b0;
    ctrl.loop_start = 1'b0;
    ctrl.loop_break = 1'b0;

    if (instruction[LITERAL_FLAG_BIT]) begin
      ctrl.stack_move = MOVE_PUSH;
      ctrl.top_src = SRC_LITERAL;
    end else begin
      case (opcode_t'(instruction))
        // Binary operations consume second and top and leave one result
        OP_ADD, OP_ADDC, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
          ctrl.alu_en = 1'b1;
          ctrl.stack_move = MOVE_POP_REPLACE;
          ctrl.top_src = SRC_ALU;
          case (opcode_t'(instruction))
            OP_ADDC: ctrl.alu_op = ALU_ADDC;
            OP_SUB: ctrl.alu_op = ALU_SUB;
            OP_AND: ctrl.alu_op = ALU_AND;
            OP_OR: ctrl.alu_op = ALU_OR;
            OP_XOR: ctrl.alu_op = ALU_XOR;
            default: ctrl.alu_op = ALU_ADD;
          endcase
        end
        OP_DUP: begin
          ctrl.stack_move = MOVE_PUSH;
          ctrl.top_src = SRC_COPY;
        end
        OP_DROP: ctrl.stack_move = MOVE_POP;
        OP_SWAP: ctrl.stack_move = MOVE_SWAP;
        OP_STORE: begin
          ctrl.stack_move = MOVE_POP_TWO;
          ctrl.store = 1'b1;
        end
        // The target is read from top before the pop takes effect
        OP_JMP: begin
          ctrl.stack_move = MOVE_POP;
          ctrl.jump = 1'b1;
        end
        OP_LOOP: begin
          ctrl.stack_move = MOVE_POP_TWO;
          ctrl.loop_start = 1'b1;
        end
        OP_BREAK: ctrl.loop_break = 1'b1;
        OP_ITER: begin
          ctrl.stack_move = MOVE_PUSH;
          ctrl.top_src = SRC_INDEX;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== loop_stack.sv ====
`timescale 1ns/10ps

module loop_stack import stack_core_pkg::*; #(
  parameter int PROG_ADDR_WIDTH = 8,
  parameter int LSTACK_DEPTH = 3
) (
  input logic clk,
  input logic reset,
  stack_core_if.sequencer ctrl,
  input logic [PROG_ADDR_WIDTH-1:0] pc,
  input word_t top,
  input word_t second,
  output word_t index,
  output logic loop_exit,
  output logic loop_iterate,
  output logic [PROG_ADDR_WIDTH-1:0] loop_begin,
  output logic [PROG_ADDR_WIDTH-1:0] loop_after_end
);

  // One saved loop holds index, total, beginning and end
  localparam int ENTRY_WIDTH = 2 * WORD_WIDTH + 2 * PROG_ADDR_WIDTH;

  word_t total;
  logic [PROG_ADDR_WIDTH-1:0] ending;
  word_t index_next;
  logic [ENTRY_WIDTH-1:0] active_entry;
  logic [ENTRY_WIDTH-1:0] saved [LSTACK_DEPTH];

  assign index_next = index + 1'b1;
  assign loop_after_end = ending + 1'b1;
  assign loop_iterate = (pc == ending);
  assign loop_exit = ctrl.loop_break || (loop_iterate && index_next == total);
  assign active_entry = {index, total, loop_begin, ending};

  // Active loop. Out of reset it spans the whole program memory, so a
  // program that runs off the last address starts again at zero
  always_ff @(posedge clk) begin
    if (reset) begin
      index <= '0;
      total <= '0;
      loop_begin <= '0;
      ending <= '1;
    end else if (ctrl.loop_start) begin
      index <= '0;
      total <= second;
      loop_begin <= pc + 1'b1;
      ending <= top[PROG_ADDR_WIDTH-1:0];
    end else if (loop_exit) begin
      {index, total, loop_begin, ending} <= saved[0];
    end else if (loop_iterate) begin
      index <= index_next;
    end
  end

  // Outer loops shift down on LOOP and back up on exit
  always_ff @(posedge clk) begin
    if (ctrl.loop_start) begin
      saved[0] <= active_entry;
      for (int i = 1; i < LSTACK_DEPTH; i++) begin
        saved[i] <= saved[i-1];
      end
    end else if (loop_exit) begin
      for (int i = 0; i < LSTACK_DEPTH - 1; i++) begin
        saved[i] <= saved[i+1];
      end
    end
  end

endmodule

// ==== pc_sequencer.sv ====
`timescale 1ns/10ps

module pc_sequencer import stack_core_pkg::*; #(
  parameter int PROG_ADDR_WIDTH = 8
) (
  input logic clk,
  input logic reset,
  stack_core_if.sequencer ctrl,
  input word_t top,
  input logic loop_exit,
  input logic loop_iterate,
  input logic [PROG_ADDR_WIDTH-1:0] loop_begin,
  input logic [PROG_ADDR_WIDTH-1:0] loop_after_end,
  output logic [PROG_ADDR_WIDTH-1:0] pc,
  output logic [PROG_ADDR_WIDTH-1:0] programmem_addr
);

  logic [PROG_ADDR_WIDTH-1:0] pc_advance;

  assign pc_advance = pc + 1'b1;

  // The next address goes straight to program memory, whose byte comes
  // back one cycle later as the instruction at pc
  always_comb begin
    if (reset) begin
      programmem_addr = '0;
    end else if (ctrl.jump) begin
      programmem_addr = top[PROG_ADDR_WIDTH-1:0];
    end else if (loop_exit) begin
      programmem_addr = loop_after_end;
    end else if (loop_iterate) begin
      programmem_addr = loop_begin;
    end else begin
      programmem_addr = pc_advance;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= programmem_addr;
    end
  end

endmodule

// ==== project.f ====
stack_core_pkg.sv
stack_core_if.sv
instruction_decoder.sv
alu.sv
data_stack.sv
loop_stack.sv
pc_sequencer.sv
core_top.sv
core_chk.sv
tb_core.sv

// ==== stack_core_if.sv ====
`timescale 1ns/10ps

// Decoded control for one instruction, valid for the cycle it executes in
interface stack_core_if import stack_core_pkg::*; ();

  alu_op_t alu_op;
  logic alu_en;

  stack_move_t stack_move;
  top_src_t top_src;
  literal_t literal;

  logic store;
  logic jump;
  logic loop_start;
  logic loop_break;

  modport decoder (
    output alu_op, alu_en, stack_move, top_src, literal,
    output store, jump, loop_start, loop_break
  );

  modport alu (input alu_op, alu_en);

  modport stack (input stack_move, top_src, literal);

  modport sequencer (input jump, loop_start, loop_break);

endinterface

// ==== stack_core_pkg.sv ====
package stack_core_pkg;

  localparam int WORD_WIDTH = 16;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [7:0] instr_t;

  // A byte with this bit set pushes its low bits as an unsigned literal
  localparam int LITERAL_FLAG_BIT = 7;
  typedef logic [LITERAL_FLAG_BIT-1:0] literal_t;

  // Bytes with bit 7 clear that are not listed here behave as NOP
  typedef enum instr_t {
    OP_NOP   = 8'h00,
    OP_ADD   = 8'h01,
    OP_ADDC  = 8'h02,
    OP_SUB   = 8'h03,
    OP_AND   = 8'h04,
    OP_OR    = 8'h05,
    OP_XOR   = 8'h06,
    OP_DUP   = 8'h10,
    OP_DROP  = 8'h11,
    OP_SWAP  = 8'h12,
    OP_STORE = 8'h20,
    OP_JMP   = 8'h30,
    OP_LOOP  = 8'h40,
    OP_BREAK = 8'h41,
    OP_ITER  = 8'h42
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_ADDC,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_t;

  typedef enum logic [2:0] {
    MOVE_HOLD,
    MOVE_PUSH,
    MOVE_POP,
    MOVE_POP_REPLACE,
    MOVE_POP_TWO,
    MOVE_SWAP
  } stack_move_t;

  typedef enum logic [1:0] {
    SRC_LITERAL,
    SRC_ALU,
    SRC_INDEX,
    SRC_COPY
  } top_src_t;

endpackage

// ==== tb_core.sv ====
`timescale 1ns/10ps

module tb_core import stack_core_pkg::*; ();

  localparam int PROG_ADDR_WIDTH = 8;
  localparam int MAIN_ADDR_WIDTH = 8;
  localparam int PROG_SIZE = 1 << PROG_ADDR_WIDTH;
  // The spin literal holds its own address, so it must fit in 7 bits
  localparam int SPIN_LIMIT = 126;
  localparam int WAIT_CYCLES = 2000;
  localparam int SETTLE_CYCLES = 20;

  logic clk;
  logic reset;
  logic [PROG_ADDR_WIDTH-1:0] programmem_addr;
  instr_t programmem_read_value;
  logic mainmem_we;
  logic [MAIN_ADDR_WIDTH-1:0] mainmem_write_addr;
  word_t mainmem_write_value;

  instr_t prog_mem [PROG_SIZE];
  logic [PROG_ADDR_WIDTH-1:0] fetch_addr;
  int wp;
  int writes_seen;
  int expected_total;
  logic [MAIN_ADDR_WIDTH-1:0] exp_addr [$];
  word_t exp_value [$];

  core_top uut (
    .clk, .reset, .programmem_addr, .programmem_read_value,
    .mainmem_we, .mainmem_write_addr, .mainmem_write_value
  );

  bind core_top core_chk #(.PROG_ADDR_WIDTH(PROG_ADDR_WIDTH)) chk (.*);

  always #2 clk = ~clk;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Simulation stopped after a failure");
  endtask

  task automatic put_byte(input instr_t b);
    prog_mem[wp] = b;
    wp++;
  endtask

  task automatic put_literal(input int v);
    put_byte(8'h80 | instr_t'(v[6:0]));
  endtask

  task automatic put_op(input opcode_t op);
    put_byte(instr_t'(op));
  endtask

  task automatic expect_write(input int a, input word_t v);
    exp_addr.push_back(MAIN_ADDR_WIDTH'(a));
    exp_value.push_back(v);
  endtask

  // Pushes a literal address and stores second there
  task automatic store_at(input int a);
    put_literal(a);
    put_op(OP_STORE);
  endtask

  // Result is second op top, with second the first literal pushed
  task automatic build_alu_tests();
    opcode_t ops [5];
    int a;
    int b;
    word_t r;
    ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    for (int k = 0; k < 5; k++) begin
      a = $urandom % 128;
      b = $urandom % 128;
      case (ops[k])
        OP_ADD: r = word_t'(a + b);
        OP_SUB: r = word_t'(a - b);
        OP_AND: r = word_t'(a & b);
        OP_OR: r = word_t'(a | b);
        default: r = word_t'(a ^ b);
      endcase
      put_literal(a);
      put_literal(b);
      put_op(ops[k]);
      store_at(8'h10 + k);
      expect_write(8'h10 + k, r);
    end
  endtask

  task automatic build_carry_tests();
    put_literal(127);
    // Ten doublings, the last one carries out of 16 bits
    for (int k = 0; k < 10; k++) begin
      put_op(OP_DUP);
      put_op(OP_ADD);
    end
    put_literal(5);
    put_literal(6);
    put_op(OP_ADDC);
    store_at(8'h20);
    expect_write(8'h20, word_t'(5 + 6 + 1));
    put_literal(9);
    put_literal(3);
    put_op(OP_SUB);
    put_literal(1);
    put_op(OP_ADDC);
    store_at(8'h21);
    expect_write(8'h21, word_t'(9 - 3 + 1 + 1));
    put_literal(3);
    put_literal(9);
    put_op(OP_SUB);
    put_literal(1);
    put_op(OP_ADDC);
    store_at(8'h22);
    expect_write(8'h22, word_t'(3 - 9 + 1));
    store_at(8'h23);
    expect_write(8'h23, word_t'(127 * 1024));
  endtask

  task automatic build_stack_tests();
    put_literal(11);
    put_literal(22);
    put_op(OP_SWAP);
    store_at(8'h30);
    expect_write(8'h30, word_t'(11));
    store_at(8'h31);
    expect_write(8'h31, word_t'(22));
    put_literal(33);
    put_op(OP_DUP);
    store_at(8'h32);
    expect_write(8'h32, word_t'(33));
    put_literal(44);
    put_op(OP_DROP);
    store_at(8'h33);
    expect_write(8'h33, word_t'(33));
  endtask

  // Body that stores the loop index to base plus the index
  task automatic put_index_store(input int base);
    put_op(OP_ITER);
    put_op(OP_ITER);
    put_literal(base);
    put_op(OP_ADD);
    put_op(OP_STORE);
  endtask

  task automatic build_loop_tests();
    int total;
    total = $urandom % 4 + 1;
    put_literal(total);
    put_literal(wp + 6);
    put_op(OP_LOOP);
    put_index_store(8'h40);
    for (int i = 0; i < total; i++) begin
      expect_write(8'h40 + i, word_t'(i));
    end
    // Nested loop, two outer passes of two inner passes each
    put_literal(2);
    put_literal(wp + 14);
    put_op(OP_LOOP);
    put_literal(2);
    put_literal(wp + 6);
    put_op(OP_LOOP);
    put_index_store(8'h50);
    put_index_store(8'h58);
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < 2; i++) begin
        expect_write(8'h50 + i, word_t'(i));
      end
      expect_write(8'h58 + o, word_t'(o));
    end
    // BREAK in the first pass skips the rest of the body
    put_literal(3);
    put_literal(wp + 10);
    put_op(OP_LOOP);
    put_index_store(8'h60);
    put_op(OP_BREAK);
    put_literal(99);
    store_at(8'h68);
    expect_write(8'h60, word_t'(0));
  endtask

  task automatic build_jump_test();
    put_literal(wp + 5);
    put_op(OP_JMP);
    put_literal(77);
    store_at(8'h70);
    put_literal(88);
    store_at(8'h71);
    expect_write(8'h71, word_t'(88));
  endtask

  always @(negedge clk) begin
    fetch_addr = programmem_addr;
  end

  always @(posedge clk) begin
    #1;
    programmem_read_value = prog_mem[fetch_addr];
  end

  // Any failed property in core_chk ends the run
  always @(uut.chk.failures) begin
    if (uut.chk.failures != 0) begin
      stop_with_failure("A bound assertion on the core ports failed");
    end
  end

  always @(negedge clk) begin
    logic [MAIN_ADDR_WIDTH-1:0] want_addr;
    word_t want_value;
    if (!reset && mainmem_we === 1'b1) begin
      if (exp_addr.size() == 0) begin
        stop_with_failure($sformatf("Unexpected main memory write at %0t to address %0h",
                                    $time, mainmem_write_addr));
      end else begin
        want_addr = exp_addr.pop_front();
        want_value = exp_value.pop_front();
        writes_seen++;
        assert (mainmem_write_addr === want_addr)
          else stop_with_failure($sformatf(
            "Mismatch at %0t: mainmem_write_addr is %0h, expected %0h",
            $time, mainmem_write_addr, want_addr));
        assert (mainmem_write_value === want_value)
          else stop_with_failure($sformatf(
            "Mismatch at %0t: mainmem_write_value is %0h, expected %0h",
            $time, mainmem_write_value, want_value));
      end
    end
  end

  initial begin
    int cycles;
    clk = 1'b0;
    reset = 1'b1;
    programmem_read_value = 8'h00;
    fetch_addr = '0;
    wp = 0;
    writes_seen = 0;
    void'($urandom(32'hd7b9_68e1));
    for (int i = 0; i < PROG_SIZE; i++) begin
      prog_mem[i] = instr_t'((i * 37) ^ (i >> 2));
    end
    build_alu_tests();
    build_carry_tests();
    build_stack_tests();
    build_loop_tests();
    build_jump_test();
    if (wp > SPIN_LIMIT) begin
      stop_with_failure("Test program does not fit below the spin address limit");
    end
    put_literal(wp);
    put_op(OP_JMP);
    expected_total = exp_addr.size();

    repeat (2) @(posedge clk);
    #1 reset = 1'b0;

    cycles = 0;
    while (writes_seen < expected_total && cycles < WAIT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (writes_seen < expected_total) begin
      stop_with_failure("Timed out waiting for the expected main memory writes");
    end

    // The core now spins, any further write is caught by the monitor
    for (int k = 0; k < SETTLE_CYCLES; k++) begin
      @(negedge clk);
    end

    if (writes_seen == expected_total && exp_addr.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_with_failure("Write count differs from the expected list");
    end
  end

endmodule
